// File: Makefile
TOP = tb_eeprom_ctrl

.PHONY: all lint clean

# build, run, then decide pass or fail from the log
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

obj_dir/V$(TOP): sim.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

// File: rtl/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top import i2c_pkg::*, eeprom_pkg::*; #(
  parameter int                    DIV      = 25,
  parameter logic [DEV_ADDR_W-1:0] DEV_ADDR = DEV_ADDR_DEFAULT
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  input  logic              rd,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata,
  output logic              busy,
  output logic              done,
  output logic              nack,
  output logic              scl,
  inout  wire               sda
);

  logic              frame_go;
  frame_t            frame_kind;
  logic [DATA_W-1:0] frame_byte;
  logic              frame_done;
  logic              frame_ack;
  logic [DATA_W-1:0] rx_byte;
  logic              sda_oe;
  logic              sda_in;

  // open drain, the pull-up sits outside
  assign sda    = sda_oe ? 1'b0 : 1'bz;
  assign sda_in = sda;

  eeprom_sequencer #(
    .DEV_ADDR (DEV_ADDR)
  ) seq_i (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .rd         (rd),
    .addr       (addr),
    .wdata      (wdata),
    .frame_done (frame_done),
    .frame_ack  (frame_ack),
    .rx_byte    (rx_byte),
    .frame_go   (frame_go),
    .frame_kind (frame_kind),
    .frame_byte (frame_byte),
    .rdata      (rdata),
    .busy       (busy),
    .done       (done),
    .nack       (nack)
  );

  i2c_byte_engine #(
    .DIV (DIV)
  ) eng_i (
    .clk        (clk),
    .rstn       (rstn),
    .frame_go   (frame_go),
    .frame_kind (frame_kind),
    .frame_byte (frame_byte),
    .sda_in     (sda_in),
    .frame_done (frame_done),
    .frame_ack  (frame_ack),
    .rx_byte    (rx_byte),
    .scl        (scl),
    .sda_oe     (sda_oe)
  );

endmodule

// File: rtl/eeprom_pkg.sv
package eeprom_pkg;

  localparam int ADDR_W = 16;  // two address bytes, high first
  localparam int DATA_W = 8;

  localparam int DEV_ADDR_W = 7;

  // 1010 family code, chip select pins tied to 011
  localparam logic [DEV_ADDR_W-1:0] DEV_ADDR_DEFAULT = 7'b1010011;

  localparam logic RW_WRITE = 1'b0;
  localparam logic RW_READ  = 1'b1;

endpackage

// File: rtl/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer import i2c_pkg::*, eeprom_pkg::*; #(
  parameter logic [DEV_ADDR_W-1:0] DEV_ADDR = DEV_ADDR_DEFAULT
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  input  logic              rd,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  input  logic              frame_done,
  input  logic              frame_ack,
  input  logic [DATA_W-1:0] rx_byte,
  output logic              frame_go,
  output frame_t            frame_kind,
  output logic [DATA_W-1:0] frame_byte,
  output logic [DATA_W-1:0] rdata,
  output logic              busy,
  output logic              done,
  output logic              nack
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_DEV_W,
    S_ADDR_HI,
    S_ADDR_LO,
    S_WR_DATA,
    S_DEV_R,
    S_RD_DATA,
    S_STOP
  } state_t;

  state_t            state;
  state_t            next_tx;  // where an acked byte leads
  logic              rd_q;
  logic              err;      // some byte went unacked
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;

  always_comb
  begin
    case (state)
      S_DEV_W:   next_tx = S_ADDR_HI;
      S_ADDR_HI: next_tx = S_ADDR_LO;
      S_ADDR_LO: next_tx = rd_q ? S_DEV_R : S_WR_DATA;
      S_DEV_R:   next_tx = S_RD_DATA;
      default:   next_tx = S_STOP;  // after the write data byte
    endcase
  end

  // frame contents follow the state, so they are valid with frame_go
  always_comb
  begin
    case (state)
      S_DEV_W:   frame_kind = frame_start_tx;
      S_DEV_R:   frame_kind = frame_restart_tx;
      S_RD_DATA: frame_kind = frame_rx_nack;
      S_ADDR_HI,
      S_ADDR_LO,
      S_WR_DATA: frame_kind = frame_tx;
      default:   frame_kind = frame_stop;
    endcase
  end

  always_comb
  begin
    case (state)
      S_DEV_W:   frame_byte = {DEV_ADDR, RW_WRITE};
      S_DEV_R:   frame_byte = {DEV_ADDR, RW_READ};
      S_ADDR_HI: frame_byte = addr_q[ADDR_W-1:DATA_W];
      S_ADDR_LO: frame_byte = addr_q[DATA_W-1:0];
      default:   frame_byte = wdata_q;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (start && !busy)
    begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state    <= S_IDLE;
      frame_go <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
      nack     <= 1'b0;
      err      <= 1'b0;
      rd_q     <= 1'b0;
      rdata    <= '0;
    end
    else
    begin
      frame_go <= 1'b0;
      done     <= 1'b0;
      if (done)
        busy <= 1'b0;  // drops one cycle after done
      case (state)
        S_IDLE:
          if (start && !busy)  // start while busy is dropped
          begin
            state    <= S_DEV_W;
            frame_go <= 1'b1;
            busy     <= 1'b1;
            err      <= 1'b0;
            nack     <= 1'b0;
            rd_q     <= rd;
          end
        S_RD_DATA:
          if (frame_done)
          begin
            rdata    <= rx_byte;
            state    <= S_STOP;
            frame_go <= 1'b1;
          end
        S_STOP:
          if (frame_done)
          begin
            state <= S_IDLE;
            done  <= 1'b1;
            nack  <= err;
          end
        default:  // every transmitted byte must be acked
          if (frame_done)
          begin
            frame_go <= 1'b1;
            if (!frame_ack)
            begin
              err   <= 1'b1;
              state <= S_STOP;  // skip straight to the stop
            end
            else
              state <= next_tx;
          end
      endcase
    end
  end

endmodule

// File: rtl/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine import i2c_pkg::*; #(
  parameter int DIV = 25
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 frame_go,
  input  frame_t               frame_kind,
  input  logic [BYTE_BITS-1:0] frame_byte,
  input  logic                 sda_in,
  output logic                 frame_done,
  output logic                 frame_ack,
  output logic [BYTE_BITS-1:0] rx_byte,
  output logic                 scl,
  output logic                 sda_oe
);

  localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;
  localparam int QTR_W = $clog2(TICKS_PER_BIT);
  localparam int BIT_W = $clog2(BYTE_BITS + 1);

  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DIV - 1);
  localparam logic [QTR_W-1:0] QTR_LAST = QTR_W'(TICKS_PER_BIT - 1);
  localparam logic [BIT_W-1:0] ACK_BIT  = BIT_W'(BYTE_BITS);

  logic                 running;
  logic                 in_cond;  // start, restart or stop quarter group
  frame_t               kind_q;
  logic [DIV_W-1:0]     div_cnt;
  logic [QTR_W-1:0]     qtr;
  logic [BIT_W-1:0]     bit_cnt;  // 0..7 data, 8 ack slot
  logic [BYTE_BITS-1:0] shreg;
  logic                 tick;
  logic                 is_stop;
  logic                 is_rx;
  logic                 last_tick;

  assign tick    = running && (div_cnt == DIV_LAST);
  assign is_stop = (kind_q == frame_stop);
  assign is_rx   = (kind_q == frame_rx_nack);
  assign rx_byte = shreg;

  // stop ends after its own group, byte frames after the ack slot
  assign last_tick = tick && (qtr == QTR_LAST) &&
                     (in_cond ? is_stop : (bit_cnt == ACK_BIT));

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      div_cnt <= '0;
    else if (frame_go || tick)
      div_cnt <= '0;
    else if (running)
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      running    <= 1'b0;
      in_cond    <= 1'b0;
      kind_q     <= frame_stop;
      qtr        <= '0;
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end
    else
    begin
      frame_done <= last_tick;
      if (frame_go)
      begin
        running <= 1'b1;
        in_cond <= (frame_kind != frame_tx) && (frame_kind != frame_rx_nack);
        kind_q  <= frame_kind;
        qtr     <= '0;
        bit_cnt <= '0;
      end
      else if (tick)
      begin
        if (qtr == QTR_LAST)
        begin
          qtr <= '0;
          if (in_cond)
            in_cond <= 1'b0;  // condition done, first data bit next
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
        else
          qtr <= qtr + 1'b1;
        if (last_tick)
          running <= 1'b0;
      end
    end
  end

  // q0 sets sda, q1 raises scl, q2 samples, q3 drops scl
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      scl       <= 1'b1;
      sda_oe    <= 1'b0;
      frame_ack <= 1'b0;
    end
    else if (tick)
    begin
      case (qtr)
        2'd0:
          if (in_cond)
            sda_oe <= is_stop;  // stop starts low, start starts released
          else
            sda_oe <= (bit_cnt != ACK_BIT) && !is_rx && !shreg[BYTE_BITS-1];
        2'd1:
          scl <= 1'b1;
        2'd2:
          if (in_cond)
            sda_oe <= !is_stop;  // sda edge with scl high
          else if (bit_cnt == ACK_BIT)
            frame_ack <= !sda_in;
        default:
          if (!(in_cond && is_stop))
            scl <= 1'b0;  // bus stays high after a stop
      endcase
    end
  end

  // one register shifts out on tx and in on rx, msb first
  always_ff @(posedge clk)
  begin
    if (frame_go)
      shreg <= frame_byte;
    else if (tick && !in_cond && (qtr == 2'd2) && (bit_cnt != ACK_BIT))
      shreg <= {shreg[BYTE_BITS-2:0], sda_in};
  end

endmodule

// File: rtl/i2c_pkg.sv
package i2c_pkg;

  // kind of frame the sequencer hands to the bit engine
  typedef enum logic [2:0] {
    frame_start_tx   = 3'd0,  // start condition, then one byte out
    frame_tx         = 3'd1,  // one byte out
    frame_restart_tx = 3'd2,  // repeated start, then one byte out
    frame_rx_nack    = 3'd3,  // one byte in, answered with nack
    frame_stop       = 3'd4   // stop condition only
  } frame_t;

  // each scl period is split into four quarters
  localparam int TICKS_PER_BIT = 4;

  localparam int BYTE_BITS = 8;  // data bits before the ack slot

endpackage

// File: sim.f
rtl/i2c_pkg.sv
rtl/eeprom_pkg.sv
rtl/i2c_byte_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/eeprom_ctrl_assert.sv
tb/tb_eeprom_ctrl.sv

// File: tb/eeprom_ctrl_assert.sv
`timescale 1ns/1ps

module eeprom_ctrl_assert (
  input logic clk,
  input logic rstn,
  input logic busy,
  input logic done,
  input logic scl,
  input logic sda_oe
);

  int fail_cnt;  // failed checks so far

  done_strobe: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
    else
    begin
      $error("done held for more than one cycle");
      fail_cnt++;
    end

  // idle bus has scl high and sda released
  idle_bus: assert property (@(posedge clk) disable iff (!rstn) !busy |-> scl && !sda_oe)
    else
    begin
      $error("bus not idle while busy is low");
      fail_cnt++;
    end

  busy_release: assert property (@(posedge clk) disable iff (!rstn) done |=> !busy)
    else
    begin
      $error("busy still high the cycle after done");
      fail_cnt++;
    end

endmodule

bind eeprom_ctrl_top eeprom_ctrl_assert assert_i (
  .clk    (clk),
  .rstn   (rstn),
  .busy   (busy),
  .done   (done),
  .scl    (scl),
  .sda_oe (sda_oe)
);

// File: tb/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model import eeprom_pkg::*; #(
  parameter logic [DEV_ADDR_W-1:0] DEV_ADDR = DEV_ADDR_DEFAULT
) (
  input  logic clk,
  input  logic rstn,
  input  logic busy,  // nacks every byte while high
  input  logic scl,
  inout  wire  sda
);

  logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
  logic [ADDR_W-1:0] ptr;
  logic [DATA_W-1:0] shreg;
  logic [3:0]        bit_cnt;    // 0..7 data, 8 ack slot
  logic [1:0]        byte_idx;   // saturates at the data byte
  logic              scl_q;
  logic              sda_q;
  logic              hi_seen;    // scl rose since the last counted fall
  logic              listening;
  logic              sending;
  logic              reading;
  logic              drive_low;

  assign sda = drive_low ? 1'b0 : 1'bz;

  initial
  begin
    for (int a = 0; a < (1 << ADDR_W); a++)
      mem[a] = a[DATA_W-1:0] ^ a[ADDR_W-1:DATA_W];  // power-up fill
  end

  // bus lines are sampled on clk, edges show up one cycle late
  always @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      ptr       <= '0;
      shreg     <= '0;
      bit_cnt   <= '0;
      byte_idx  <= '0;
      hi_seen   <= 1'b0;
      listening <= 1'b0;
      sending   <= 1'b0;
      reading   <= 1'b0;
      drive_low <= 1'b0;
    end
    else
    begin
      scl_q <= scl;
      sda_q <= sda;
      if (scl_q && scl && sda_q && !sda)  // start or repeated start
      begin
        listening <= 1'b1;
        sending   <= 1'b0;
        bit_cnt   <= '0;
        byte_idx  <= '0;
        hi_seen   <= 1'b0;
        drive_low <= 1'b0;
      end
      else if (scl_q && scl && !sda_q && sda)  // stop
      begin
        listening <= 1'b0;
        sending   <= 1'b0;
        drive_low <= 1'b0;
      end
      else if (!scl_q && scl)
      begin
        hi_seen <= 1'b1;
        if (listening && !sending && bit_cnt < 4'd8)
          shreg <= {shreg[DATA_W-2:0], sda};
      end
      else if (scl_q && !scl && hi_seen && listening)
      begin
        hi_seen <= 1'b0;
        if (bit_cnt < 4'd7)
        begin
          bit_cnt <= bit_cnt + 4'd1;
          if (sending)
          begin
            drive_low <= !shreg[DATA_W-2];
            shreg     <= {shreg[DATA_W-2:0], 1'b0};
          end
        end
        else if (bit_cnt == 4'd7)
        begin
          bit_cnt <= 4'd8;
          if (sending)
            drive_low <= 1'b0;  // master answers the read byte
          else if (busy || (byte_idx == 2'd0 && shreg[DATA_W-1:1] != DEV_ADDR))
          begin
            drive_low <= 1'b0;
            listening <= 1'b0;  // nack, wait for the next start
          end
          else
          begin
            drive_low <= 1'b1;
            case (byte_idx)
              2'd0: reading <= shreg[0];
              2'd1: ptr[ADDR_W-1:DATA_W] <= shreg;
              2'd2: ptr[DATA_W-1:0] <= shreg;
              default:
              begin
                mem[ptr] <= shreg;
                ptr      <= ptr + 16'd1;
              end
            endcase
          end
        end
        else
        begin
          bit_cnt <= '0;
          if (byte_idx != 2'd3)
            byte_idx <= byte_idx + 2'd1;
          if (sending)
          begin
            sending   <= 1'b0;
            listening <= 1'b0;  // single byte reads only
            drive_low <= 1'b0;
            ptr       <= ptr + 16'd1;
          end
          else if (reading && byte_idx == 2'd0)
          begin
            sending   <= 1'b1;
            shreg     <= mem[ptr];
            drive_low <= !mem[ptr][DATA_W-1];
          end
          else
            drive_low <= 1'b0;
        end
      end
    end
  end

endmodule

// File: tb/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl import eeprom_pkg::*; ();

  localparam int DIV     = 2;
  localparam int N_TRANS = 28;  // transactions plus the idle window of test 6

  logic              clk = 1'b0;
  logic              rstn;
  logic              start;
  logic              rd;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              busy;
  logic              done;
  logic              nack;
  logic              scl;
  wire               sda;
  logic              mdl_busy;

  logic [31:0]       lfsr = 32'haa92_93c0;
  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];  // completed writes
  logic              exp_rd [$];
  logic [DATA_W-1:0] exp_rdata [$];
  logic              exp_nack [$];
  int                err_cnt;
  int                done_cnt;
  int                tests_pass;
  int                tests_fail;

  always #2 clk = ~clk;

  pullup (sda);

  eeprom_ctrl_top #(
    .DIV (DIV)
  ) dut_i (
    .clk   (clk),
    .rstn  (rstn),
    .start (start),
    .rd    (rd),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .busy  (busy),
    .done  (done),
    .nack  (nack),
    .scl   (scl),
    .sda   (sda)
  );

  eeprom_model mdl_i (
    .clk  (clk),
    .rstn (rstn),
    .busy (mdl_busy),
    .scl  (scl),
    .sda  (sda)
  );

  function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a);
    if (shadow.exists(a))
      return shadow[a];
    return a[DATA_W-1:0] ^ a[ADDR_W-1:DATA_W];  // model fill
  endfunction

  // 32-bit fibonacci lfsr with taps 32 22 2 1
  task automatic take_bits(input int n, output logic [15:0] v);
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic problem(input string what);
    $display("failure at %0t ns: %s", $time, what);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
    begin
      $display("test %s: ok", name);
      tests_pass++;
    end
    else
    begin
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
      tests_fail++;
    end
  endtask

  task automatic expect_trans(input logic is_rd, input logic [ADDR_W-1:0] a);
    exp_rd.push_back(is_rd);
    exp_rdata.push_back(ref_read(a));
    exp_nack.push_back(mdl_busy);  // a busy model nacks the device address
  endtask

  // call on a rising edge
  task automatic issue(input logic is_rd, input logic [ADDR_W-1:0] a,
                       input logic [DATA_W-1:0] d);
    start <= 1'b1;
    rd    <= is_rd;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    do
      @(posedge clk);
    while (done !== 1'b1);
    @(posedge clk);  // compare process is through by now
  endtask

  task automatic run_trans(input logic is_rd, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] d);
    @(posedge clk);
    expect_trans(is_rd, a);
    issue(is_rd, a, d);
    wait_done();
    if (!is_rd && !mdl_busy)
      shadow[a] = d;
  endtask

  always @(posedge clk)
  begin : compare
    logic              e_rd;
    logic [DATA_W-1:0] e_rdata;
    logic              e_nack;
    if (done === 1'b1)
    begin
      done_cnt++;
      if (exp_rd.size() == 0)
        problem("done came with no request outstanding");
      else
      begin
        e_rd    = exp_rd.pop_front();
        e_rdata = exp_rdata.pop_front();
        e_nack  = exp_nack.pop_front();
        if (nack !== e_nack)
          mismatch("nack", nack, e_nack);
        if (e_rd && !e_nack && rdata !== e_rdata)
          mismatch("rdata", rdata, e_rdata);
      end
    end
  end

  initial
  begin
    #(N_TRANS * 300 * DIV * 4);
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    logic [15:0] v;
    logic [15:0] a;
    logic [15:0] d;
    int          errs;
    int          dones;
    rstn     = 1'b0;
    start    = 1'b0;
    rd       = 1'b0;
    addr     = '0;
    wdata    = '0;
    mdl_busy = 1'b0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    errs = err_cnt;
    if (busy !== 1'b0)
      mismatch("busy", busy, 0);
    if (done !== 1'b0)
      mismatch("done", done, 0);
    if (nack !== 1'b0)
      mismatch("nack", nack, 0);
    if (rdata !== '0)
      mismatch("rdata", rdata, 0);
    if (scl !== 1'b1)
      mismatch("scl", scl, 1);
    if (sda !== 1'b1)
      mismatch("sda", sda, 1);
    finish_test("reset state", errs);

    errs = err_cnt;
    run_trans(1'b0, 16'h1234, 8'ha7);
    run_trans(1'b1, 16'h1234, 8'h00);
    finish_test("write then read", errs);

    errs = err_cnt;
    for (int i = 0; i < 20; i++)
    begin
      take_bits(1, v);
      take_bits(3, a);  // few addresses, so reads hit earlier writes
      take_bits(8, d);
      run_trans(v[0], 16'h5a30 + a, d[DATA_W-1:0]);
    end
    finish_test("random writes and reads", errs);

    errs = err_cnt;
    a = 16'hc3a5;
    while (shadow.exists(a))
      a = a + 16'd1;
    run_trans(1'b1, a, 8'h00);
    finish_test("unwritten read", errs);

    errs = err_cnt;
    mdl_busy <= 1'b1;
    run_trans(1'b0, 16'h1234, 8'h5e);
    mdl_busy <= 1'b0;
    run_trans(1'b1, 16'h1234, 8'h00);
    finish_test("busy device", errs);

    errs  = err_cnt;
    dones = done_cnt;
    a     = 16'h0f1e;
    @(posedge clk);
    expect_trans(1'b0, a);
    issue(1'b0, a, 8'h3c);
    repeat (10) @(posedge clk);
    if (busy !== 1'b1)
      problem("busy was not high when the second start was raised");
    issue(1'b0, a, 8'hc3);  // dropped by the sequencer
    wait_done();
    shadow[a] = 8'h3c;
    repeat (200 * DIV) @(posedge clk);  // room for a stray second write
    if (done_cnt - dones != 1)
      mismatch("done count", done_cnt - dones, 1);
    run_trans(1'b1, a, 8'h00);
    finish_test("start while busy", errs);

    if (dut_i.assert_i.fail_cnt != 0)
      problem("one or more DUT assertions failed during the run");

    $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_cnt);
    if (err_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
